// ==== bench/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    output logic sda_drive   // 1 pulls sda low
);

    logic [7:0] mem [0:1023];
    logic scl_q;
    logic sda_q;
    logic start_cond;
    logic stop_cond;
    logic rise;
    logic fall;
    logic active;
    logic sending;
    logic reading;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [1:0] byte_idx;
    logic [9:0] ptr;

    initial
    begin
        for (int i = 0; i < 1024; i++)
            mem[10'(i)] = 8'((i * 7) ^ (i >> 3));
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        sda_drive = 1'b0;
        active    = 1'b0;
        sending   = 1'b0;
        reading   = 1'b0;
        bit_cnt   = '0;
        shreg     = '0;
        byte_idx  = '0;
        ptr       = '0;
    end

    // bus levels are stable at the falling clock edge
    always @(negedge CLK)
    begin
        start_cond = scl && scl_q && sda_q && !sda;
        stop_cond  = scl && scl_q && !sda_q && sda;
        rise       = scl && !scl_q;
        fall       = !scl && scl_q;
        if (start_cond)
        begin
            active    = 1'b1;
            sending   = 1'b0;
            reading   = 1'b0;
            bit_cnt   = '0;
            byte_idx  = '0;
            sda_drive = 1'b0;
        end
        else if (stop_cond)
        begin
            active    = 1'b0;
            sda_drive = 1'b0;
        end
        else if (active && rise)
        begin
            if (!sending && bit_cnt < 4'd8)
                shreg = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 4'd1;   // ninth rise is the ack slot
        end
        else if (active && fall)
        begin
            if (bit_cnt == 4'd9)
            begin
                bit_cnt   = '0;
                sda_drive = 1'b0;
                if (sending)
                begin
                    active  = 1'b0;   // one byte only, then wait for stop
                    sending = 1'b0;
                end
                else if (reading)
                begin
                    sending   = 1'b1;
                    shreg     = mem[ptr];
                    sda_drive = !shreg[7];
                end
            end
            else if (sending)
            begin
                shreg     = {shreg[6:0], 1'b0};
                sda_drive = (bit_cnt == 4'd8) ? 1'b0 : !shreg[7];   // free sda for master ack
            end
            else if (bit_cnt == 4'd8)
            begin
                if (byte_idx == 2'd0)
                begin
                    // control byte, blocks 4 to 7 get no answer
                    if (shreg[7:4] == 4'b1010 && !shreg[3])
                    begin
                        sda_drive = 1'b1;
                        ptr[9:8]  = shreg[2:1];
                        reading   = shreg[0];
                        byte_idx  = 2'd1;
                    end
                    else
                        active = 1'b0;
                end
                else if (byte_idx == 2'd1)
                begin
                    sda_drive = 1'b1;
                    ptr[7:0]  = shreg;
                    byte_idx  = 2'd2;
                end
                else
                begin
                    sda_drive = 1'b1;
                    mem[ptr]  = shreg;
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== bench/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    import eeprom_pkg::*;

    localparam int TXN_MAX     = 40;
    localparam int TXN_CYCLES  = 300;   // a random read needs about 170
    localparam int CYCLE_LIMIT = TXN_MAX * TXN_CYCLES;

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic ack;
    logic nack;
    logic busy;
    logic scl;
    logic sda_oe;
    logic sda_in;
    logic model_drive;

    logic [7:0] ref_mem [0:1023];
    int errors = 0;
    int checks = 0;
    int acks = 0;
    int cycles = 0;
    integer seed;

    assign sda_in = !(sda_oe || model_drive);   // pulled up unless someone pulls low

    eeprom_ctrl eeprom_ctrl_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .ack    (ack),
        .nack   (nack),
        .busy   (busy),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    eeprom_model model_i (
        .CLK       (CLK),
        .scl       (scl),
        .sda       (sda_in),
        .sda_drive (model_drive)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(negedge CLK)
        if (ack)
            acks = acks + 1;

    function automatic logic [7:0] fill_value(input int i);
        return 8'((i * 7) ^ (i >> 3));
    endfunction

    // only blocks 0 to 3 are answered
    function automatic logic block_acked(input logic [ADDR_W-1:0] a);
        return a[10:8] < 3'd4;
    endfunction

    task automatic check(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic strobe(input logic w, input logic r, input logic [ADDR_W-1:0] a,
                          input logic [7:0] d);
        @(negedge CLK);
        wr    = w;
        rd    = r;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack;
        while (ack !== 1'b1)
            @(negedge CLK);
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        logic ok;
        ok = block_acked(a);
        strobe(1'b1, 1'b0, a, d);
        wait_ack();
        check($sformatf("nack of write to %h", a), 8'(nack), 8'(!ok));
        if (ok)
            ref_mem[a[9:0]] = d;
    endtask

    task automatic read_byte(input logic [ADDR_W-1:0] a);
        logic ok;
        ok = block_acked(a);
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_ack();
        check($sformatf("nack of read from %h", a), 8'(nack), 8'(!ok));
        if (ok)
            check($sformatf("data read from %h", a), rdata, ref_mem[a[9:0]]);
    endtask

    task automatic test_reset_state;
        check("ack after reset", 8'(ack), 8'h00);
        check("busy after reset", 8'(busy), 8'h00);
        check("sda_oe after reset", 8'(sda_oe), 8'h00);
        check("scl after reset", 8'(scl), 8'h01);
    endtask

    task automatic test_write_read;
        write_byte(11'h123, 8'h5a);
        read_byte(11'h123);
    endtask

    task automatic test_random_traffic;
        logic [ADDR_W-1:0] addrs [16];
        integer r;
        for (int i = 0; i < 16; i++)
        begin
            r = $random(seed);
            addrs[i] = {1'b0, r[9:0]};
            r = $random(seed);
            write_byte(addrs[i], r[7:0]);
        end
        for (int i = 0; i < 16; i++)
            read_byte(addrs[15 - i]);   // reverse order
    endtask

    task automatic test_missing_ack;
        write_byte(11'h5a7, 8'hc3);
        read_byte(11'h6e0);
        read_byte(11'h1a7);   // same low bits as the lost write
    endtask

    task automatic test_busy_drop;
        int acks_before;
        strobe(1'b1, 1'b0, 11'h0c4, 8'h3c);
        acks_before = acks;   // previous ack already counted here
        check("busy after accepted write", 8'(busy), 8'h01);
        strobe(1'b1, 1'b0, 11'h2e9, 8'hc4);
        wait_ack();
        check("nack of first write", 8'(nack), 8'h00);
        ref_mem[10'h0c4] = 8'h3c;
        @(negedge CLK);
        check("busy after ack", 8'(busy), 8'h00);
        check("acks for one accepted request", 8'(acks - acks_before), 8'h01);
        read_byte(11'h2e9);
        read_byte(11'h0c4);
    endtask

    task automatic test_simultaneous;
        strobe(1'b1, 1'b1, 11'h3f1, 8'h96);
        wait_ack();
        check("nack of combined strobe", 8'(nack), 8'h00);
        ref_mem[10'h3f1] = 8'h96;
        read_byte(11'h3f1);
    endtask

    task automatic finish_run;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    initial
    begin
        seed  = 32'he6c3_b2a3;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 1024; i++)
            ref_mem[10'(i)] = fill_value(i);
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        test_reset_state();
        test_write_read();
        test_random_traffic();
        test_missing_ack();
        test_busy_drop();
        test_simultaneous();
        finish_run();
    end

    initial
    begin
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
        errors++;
        finish_run();
    end

endmodule

// ==== run.sh ====
#!/bin/sh

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_eeprom_ctrl -f vlog.f -o tb_eeprom_ctrl > build.log 2>&1 \
    && ./obj_dir/tb_eeprom_ctrl > sim.log 2>&1 \
    && grep -q 'All tests passed!' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== src/eeprom_ctrl.sv ====
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          nack,
    output logic                          busy,
    output logic                          scl,
    output logic                          sda_oe,
    input  logic                          sda_in
);

    import eeprom_pkg::*;
    import i2c_pkg::*;

    eeprom_req_t req;
    eeprom_rsp_t rsp;
    logic start;
    logic done;
    bus_cmd_t cmd;
    bus_rsp_t brsp;
    logic cmd_go;
    logic cmd_done;

    eeprom_host_port host_port_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .req   (req),
        .start (start),
        .rsp   (rsp),
        .done  (done),
        .rdata (rdata),
        .nack  (nack),
        .ack   (ack),
        .busy  (busy)
    );

    eeprom_sequencer sequencer_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .start    (start),
        .rsp      (rsp),
        .done     (done),
        .cmd      (cmd),
        .cmd_go   (cmd_go),
        .cmd_done (cmd_done),
        .brsp     (brsp)
    );

    i2c_bit_engine bit_engine_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd      (cmd),
        .cmd_go   (cmd_go),
        .cmd_done (cmd_done),
        .brsp     (brsp),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

// ==== src/eeprom_host_port.sv ====
`timescale 1ns/1ps

module eeprom_host_port (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           wr,
    input  logic                           rd,
    input  logic [eeprom_pkg::ADDR_W-1:0]  addr,
    input  logic [eeprom_pkg::DATA_W-1:0]  wdata,
    output eeprom_pkg::eeprom_req_t        req,
    output logic                           start,
    input  eeprom_pkg::eeprom_rsp_t        rsp,
    input  logic                           done,
    output logic [eeprom_pkg::DATA_W-1:0]  rdata,
    output logic                           nack,
    output logic                           ack,
    output logic                           busy
);

    logic accept;

    assign accept = !busy && (wr || rd);   // strobes while busy are lost

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy  <= 1'b0;
            start <= 1'b0;
            ack   <= 1'b0;
        end
        else
        begin
            start <= accept;
            ack   <= done;
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.write <= wr;   // write wins over a read in the same cycle
            req.addr  <= addr;
            req.wdata <= wdata;
        end
        if (done)
        begin
            rdata <= rsp.rdata;
            nack  <= rsp.nack;
        end
    end

endmodule

// ==== src/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // device-type nibble of the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // request captured from the host strobes
    typedef struct packed {
        logic              write;   // 1 write, 0 random read
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } eeprom_req_t;

    // result of one transaction
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              nack;    // some byte we sent was not acknowledged
    } eeprom_rsp_t;

endpackage

// ==== src/eeprom_sequencer.sv ====
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    start,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    done,
    output i2c_pkg::bus_cmd_t       cmd,
    output logic                    cmd_go,
    input  logic                    cmd_done,
    input  i2c_pkg::bus_rsp_t       brsp
);

    import eeprom_pkg::*;
    import i2c_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR_LO,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_FINISH
    } state_e;

    state_e state;
    state_e state_nxt;
    logic issue;
    logic miss;
    logic nack_q;
    logic [DATA_W-1:0] rdata_q;

    // bus command belonging to a state
    function automatic bus_cmd_t cmd_for(input state_e s, input eeprom_req_t r);
        bus_cmd_t c;
        c.op   = OP_WRITE;
        c.data = r.wdata;
        c.last = 1'b0;
        case (s)
            S_START, S_RESTART:
                c.op = OP_START;
            S_CTRL_W:
                c.data = {DEV_TYPE, r.addr[ADDR_W-1:DATA_W], 1'b0};  // block bits + write
            S_ADDR_LO:
                c.data = r.addr[DATA_W-1:0];
            S_CTRL_R:
                c.data = {DEV_TYPE, r.addr[ADDR_W-1:DATA_W], 1'b1};
            S_READ:
            begin
                c.op   = OP_READ;
                c.last = 1'b1;   // single byte, answered with nack
            end
            S_STOP:
                c.op = OP_STOP;
            default:
                c.op = OP_WRITE;
        endcase
        return c;
    endfunction

    // a written byte came back without ack
    assign miss = cmd_done && !brsp.ack_rx &&
                  (state inside {S_CTRL_W, S_ADDR_LO, S_DATA_W, S_CTRL_R});

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
                if (start)
                    state_nxt = S_START;
            S_START:
                if (cmd_done)
                    state_nxt = S_CTRL_W;
            S_CTRL_W:
                if (cmd_done)
                    state_nxt = miss ? S_STOP : S_ADDR_LO;
            S_ADDR_LO:
                if (cmd_done)
                begin
                    if (miss)
                        state_nxt = S_STOP;
                    else
                        state_nxt = req.write ? S_DATA_W : S_RESTART;
                end
            S_DATA_W, S_READ:
                if (cmd_done)
                    state_nxt = S_STOP;
            S_RESTART:
                if (cmd_done)
                    state_nxt = S_CTRL_R;
            S_CTRL_R:
                if (cmd_done)
                    state_nxt = miss ? S_STOP : S_READ;
            S_STOP:
                if (cmd_done)
                    state_nxt = S_FINISH;
            default:
                state_nxt = S_IDLE;   // FINISH lasts one cycle
        endcase
    end

    // every entry into a bus state launches its command
    assign issue = (state_nxt != state) && !(state_nxt inside {S_IDLE, S_FINISH});

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            cmd_go <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            state  <= state_nxt;
            cmd_go <= issue;
            if (state == S_IDLE && start)
                nack_q <= 1'b0;
            else if (miss)
                nack_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (issue)
            cmd <= cmd_for(state_nxt, req);
        if (state == S_READ && cmd_done)
            rdata_q <= brsp.data;
    end

    assign done = (state == S_FINISH);
    assign rsp  = '{rdata: rdata_q, nack: nack_q};

endmodule

// ==== src/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic              CLK,
    input  logic              RESET,
    input  i2c_pkg::bus_cmd_t cmd,
    input  logic              cmd_go,
    output logic              cmd_done,
    output i2c_pkg::bus_rsp_t brsp,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    import i2c_pkg::*;

    logic active;
    bus_cmd_t cmd_q;
    logic [PH_W-1:0] phase;
    logic [BIT_W-1:0] bit_cnt;
    logic [7:0] shreg;
    logic ack_q;
    logic scl_hold;   // bus levels kept between commands
    logic oe_hold;
    logic oe_bit;
    logic last_phase;
    logic last_bit;
    logic in_byte;

    assign last_phase = (phase == PH_W'(BIT_CLKS - 1));
    assign in_byte    = (bit_cnt != BIT_W'(BYTE_BITS - 1));
    assign last_bit   = (cmd_q.op inside {OP_START, OP_STOP}) || !in_byte;
    assign cmd_done   = active && last_phase && last_bit;

    always_comb
    begin
        case (cmd_q.op)
            OP_START:
                oe_bit = last_phase;    // sda falls with scl high
            OP_STOP:
                oe_bit = !last_phase;   // sda rises with scl high
            OP_WRITE:
                oe_bit = in_byte ? !shreg[7] : 1'b0;   // msb first, then free for ack
            default:
                oe_bit = in_byte ? 1'b0 : !cmd_q.last;
        endcase
    end

    assign scl    = active ? (phase >= PH_W'(SAMPLE_PH)) : scl_hold;
    assign sda_oe = active ? oe_bit : oe_hold;
    assign brsp   = '{data: shreg, ack_rx: ack_q};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            phase    <= '0;
            bit_cnt  <= '0;
            scl_hold <= 1'b1;
            oe_hold  <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_go)
            begin
                active  <= 1'b1;
                phase   <= '0;
                bit_cnt <= '0;
            end
        end
        else
        begin
            phase <= last_phase ? '0 : phase + 1'b1;
            if (last_phase)
                bit_cnt <= bit_cnt + 1'b1;
            if (cmd_done)
            begin
                active   <= 1'b0;
                scl_hold <= (cmd_q.op == OP_STOP);   // only stop leaves scl high
                oe_hold  <= oe_bit;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && cmd_go)
        begin
            cmd_q <= cmd;
            shreg <= cmd.data;
            ack_q <= 1'b0;
        end
        else if (active && in_byte)
        begin
            if (cmd_q.op == OP_READ && phase == PH_W'(SAMPLE_PH))
                shreg <= {shreg[6:0], sda_in};
            if (cmd_q.op == OP_WRITE && last_phase)
                shreg <= {shreg[6:0], 1'b0};
        end
        else if (active && cmd_q.op == OP_WRITE && phase == PH_W'(SAMPLE_PH))
            ack_q <= !sda_in;   // slave holds sda low in the ninth bit
    end

endmodule

// ==== src/i2c_pkg.sv ====
package i2c_pkg;

    // clk cycles per scl period, scl high from SAMPLE_PH on
    localparam int BIT_CLKS  = 4;
    localparam int PH_W      = $clog2(BIT_CLKS);
    localparam int SAMPLE_PH = BIT_CLKS / 2;

    // 8 data bits plus the ack slot
    localparam int BYTE_BITS = 9;
    localparam int BIT_W     = $clog2(BYTE_BITS);

    typedef enum logic [1:0] {
        OP_START,   // also used for repeated start
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bus_op_e;

    typedef struct packed {
        bus_op_e    op;
        logic [7:0] data;
        logic       last;   // answer the read byte with nack
    } bus_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ack_rx;
    } bus_rsp_t;

endpackage

// ==== vlog.f ====
src/eeprom_pkg.sv
src/i2c_pkg.sv
src/eeprom_host_port.sv
src/eeprom_sequencer.sv
src/i2c_bit_engine.sv
src/eeprom_ctrl.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv
